// File: Makefile
# Verilator build and run for the memory system testbench

TOP := tb_mem_system

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f design/*.sv testbench/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f

# the log decides pass or fail
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

// File: design/bank_dispatch.sv
//////////////////////////////////////////////////////////////////////
// bank dispatcher
// routes a word-address request to the bank picked by its low bits
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bank_dispatch import mem_sys_pkg::*; (
   input  bank_op_e          mem_op,
   input  logic [ADDR_W-2:0] mem_addr,
   input  logic [DATA_W-1:0] mem_wdata,
   output logic              mem_accept,
   bank_if.disp              bif [NUM_BANKS]
);
   logic [WORD_W-1:0]    sel;
   logic [NUM_BANKS-1:0] busy_vec;

   // word in line picks the bank
   assign sel = mem_addr[WORD_W-1:0];

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_port
      assign busy_vec[b] = bif[b].busy;
      // only the selected idle bank sees an opcode
      assign bif[b].req_op   = ((sel == WORD_W'(b)) && !bif[b].busy) ? mem_op : OP_NONE;
      assign bif[b].req_addr = mem_addr[ADDR_W-2:WORD_W];
      assign bif[b].req_data = mem_wdata;
   end

   // back-pressure from the addressed bank
   assign mem_accept = ~busy_vec[sel];

endmodule

// File: design/bank_if.sv
//////////////////////////////////////////////////////////////////////
// bank interface
// request and read-return signals of one memory bank
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface bank_if import mem_sys_pkg::*; ();

   // request side, owned by the dispatcher
   bank_op_e                req_op;
   logic [BANK_DEPTH_W-1:0] req_addr;
   logic [DATA_W-1:0]       req_data;

   // bank status and read return
   logic                    busy;
   logic                    ret_valid;
   logic [DATA_W-1:0]       ret_data;

   modport disp (
      output req_op, req_addr, req_data,
      input  busy
   );

   modport bank (
      input  req_op, req_addr, req_data,
      output busy, ret_valid, ret_data
   );

   modport coll (
      input ret_valid, ret_data
   );

endinterface

// File: design/cache_array.sv
//////////////////////////////////////////////////////////////////////
// cache array
// direct-mapped storage of tag, valid, dirty and four data words per
// line, with a registered lookup port, a word write and a line fill
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cache_array import mem_sys_pkg::*; (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               lookup,
   input  logic [INDEX_W-1:0] index,
   input  logic [WORD_W-1:0]  word,
   input  logic [TAG_W-1:0]   tag,
   input  logic               wr_word,
   input  logic [DATA_W-1:0]  wr_data,
   input  logic               fill_en,
   input  logic               fill_valid,
   input  logic [WORD_W-1:0]  fill_word,
   input  logic [DATA_W-1:0]  fill_data,
   input  logic               mark_dirty,
   output logic               hit,
   output logic               valid,
   output logic               dirty,
   output logic [TAG_W-1:0]   victim_tag,
   output logic [DATA_W-1:0]  rd_data
);
   localparam int NUM_LINES = 2 ** INDEX_W;

   // flat data store addressed by {index, word}
   logic [DATA_W-1:0]    data_mem [NUM_LINES * NUM_BANKS];
   logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   // data and tags
   always_ff @(posedge clk) begin
      // fill words land one per cycle as banks return them
      if (fill_valid) begin
         data_mem[{index, fill_word}] <= fill_data;
      end else if (wr_word) begin
         data_mem[{index, word}] <= wr_data;
      end
      // new tag once the last fill word is in
      if (fill_en) begin
         tag_mem[index] <= tag;
      end
      if (lookup) begin
         victim_tag <= tag_mem[index];
         rd_data    <= data_mem[{index, word}];
      end
   end

   // line state bits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (fill_en) begin
         valid_q[index] <= 1'b1;
         dirty_q[index] <= 1'b0;
      end else if (mark_dirty) begin
         dirty_q[index] <= 1'b1;
      end
   end

   // registered lookup status
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hit   <= 1'b0;
         valid <= 1'b0;
         dirty <= 1'b0;
      end else if (lookup) begin
         hit   <= valid_q[index] && (tag_mem[index] == tag);
         valid <= valid_q[index];
         dirty <= dirty_q[index];
      end
   end

endmodule

// File: design/cache_ctrl.sv
//////////////////////////////////////////////////////////////////////
// cache controller
// FSM for host lookup, dirty victim writeback, line fill through the
// banks and the registered host response
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cache_ctrl import mem_sys_pkg::*; #(
   parameter int BANK_LATENCY = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [ADDR_W-1:0]  Addr,
   input  logic [DATA_W-1:0]  DataIn,
   input  logic               Rd,
   input  logic               Wr,
   input  logic               hit,
   input  logic               valid,
   input  logic               dirty,
   input  logic [TAG_W-1:0]   victim_tag,
   input  logic [DATA_W-1:0]  rd_data,
   input  logic               mem_accept,
   input  logic               fill_valid,
   output logic               lookup,
   output logic               wr_word,
   output logic [DATA_W-1:0]  wr_data,
   output logic [INDEX_W-1:0] index,
   output logic [WORD_W-1:0]  word,
   output logic [TAG_W-1:0]   tag,
   output logic               fill_en,
   output logic               mark_dirty,
   output bank_op_e           mem_op,
   output logic [ADDR_W-2:0]  mem_addr,
   output logic [DATA_W-1:0]  mem_wdata,
   output logic [DATA_W-1:0]  DataOut,
   output logic               Done,
   output logic               Stall,
   output logic               CacheHit,
   output logic               err
);
   localparam int WAIT_W = $clog2(BANK_LATENCY + 1);

   ctrl_state_e       state;
   ctrl_state_e       state_nxt;
   logic [WORD_W-1:0] issue_cnt;
   logic [WORD_W-1:0] fill_cnt;
   logic [WAIT_W-1:0] wait_cnt;
   logic              hit_q;
   logic              err_q;
   logic              req;
   logic              issued;
   logic              drain_end;

   assign req       = Rd | Wr;
   assign issued    = (mem_op != OP_NONE) && mem_accept;
   assign drain_end = (wait_cnt == WAIT_W'(BANK_LATENCY - 1));

   // address fields of the held host request
   assign tag   = Addr[ADDR_W-1 -: TAG_W];
   assign index = Addr[WORD_W+1 +: INDEX_W];

   assign wr_data   = DataIn;
   // writeback data comes straight off the lookup read port
   assign mem_wdata = rd_data;
   // lookup in ST_ACCESS refreshes this for the Done cycle
   assign DataOut   = rd_data;

   always_comb begin
      state_nxt  = state;
      lookup     = 1'b0;
      word       = Addr[1 +: WORD_W];
      wr_word    = 1'b0;
      mark_dirty = 1'b0;
      fill_en    = 1'b0;
      mem_op     = OP_NONE;
      mem_addr   = {tag, index, issue_cnt};
      case (state)
         ST_IDLE: begin
            if (req) begin
               // odd address gets no lookup, only err later
               lookup    = ~Addr[0];
               state_nxt = ST_COMPARE;
            end
         end
         ST_COMPARE: begin
            if (err_q || hit) begin
               state_nxt = ST_ACCESS;
            end else if (valid && dirty) begin
               // start walking the victim at word 0
               lookup    = 1'b1;
               word      = '0;
               state_nxt = ST_WB_ISSUE;
            end else begin
               state_nxt = ST_FILL_ISSUE;
            end
         end
         ST_WB_ISSUE: begin
            mem_op   = OP_WRITE;
            mem_addr = {victim_tag, index, issue_cnt};
            // next word read only once this one is taken
            lookup   = mem_accept;
            word     = issue_cnt + 1'b1;
            if (mem_accept && (issue_cnt == '1)) begin
               state_nxt = ST_WB_DRAIN;
            end
         end
         ST_WB_DRAIN: begin
            // let the writes settle before fill reads go out
            if (drain_end) begin
               state_nxt = ST_FILL_ISSUE;
            end
         end
         ST_FILL_ISSUE: begin
            mem_op = OP_READ;
            if (mem_accept && (issue_cnt == '1)) begin
               state_nxt = ST_FILL_WAIT;
            end
         end
         ST_FILL_WAIT: begin
            // fourth return commits the line
            if (fill_valid && (fill_cnt == '1)) begin
               fill_en   = 1'b1;
               state_nxt = ST_ACCESS;
            end
         end
         ST_ACCESS: begin
            if (!err_q) begin
               lookup     = Rd;
               wr_word    = Wr;
               mark_dirty = Wr;
            end
            state_nxt = ST_DONE;
         end
         ST_DONE: begin
            // request lines ignored here
            state_nxt = ST_IDLE;
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         issue_cnt <= '0;
         fill_cnt  <= '0;
         wait_cnt  <= '0;
         hit_q     <= 1'b0;
         err_q     <= 1'b0;
         Done      <= 1'b0;
         Stall     <= 1'b0;
         CacheHit  <= 1'b0;
         err       <= 1'b0;
      end else begin
         state <= state_nxt;
         // both counters wrap back to 0 after four
         if (issued) begin
            issue_cnt <= issue_cnt + 1'b1;
         end
         if (fill_valid) begin
            fill_cnt <= fill_cnt + 1'b1;
         end
         if (state == ST_WB_DRAIN) begin
            wait_cnt <= drain_end ? '0 : wait_cnt + 1'b1;
         end
         if ((state == ST_IDLE) && req) begin
            err_q <= Addr[0];
         end
         if (state == ST_COMPARE) begin
            hit_q <= hit && !err_q;
         end
         // host response, one-cycle pulses in ST_DONE
         Done     <= (state == ST_ACCESS);
         CacheHit <= (state == ST_ACCESS) && hit_q;
         err      <= (state == ST_ACCESS) && err_q;
         Stall    <= (state_nxt != ST_IDLE) && (state_nxt != ST_DONE);
      end
   end

endmodule

// File: design/mem_bank.sv
//////////////////////////////////////////////////////////////////////
// memory bank
// 8K words with a fixed-latency read pipeline and a busy counter
// that blocks new requests while an access is in flight
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_bank import mem_sys_pkg::*; #(
   parameter int BANK_LATENCY = 4
) (
   input  logic clk,
   input  logic rst_n,
   bank_if.bank bif
);
   localparam int DEPTH  = 2 ** BANK_DEPTH_W;
   localparam int BUSY_W = $clog2(BANK_LATENCY + 1);

   logic [DATA_W-1:0]       storage [DEPTH];
   logic [DATA_W-1:0]       pipe_data [BANK_LATENCY];
   logic [BANK_LATENCY-1:0] pipe_vld;
   logic [BUSY_W-1:0]       busy_cnt;
   logic                    accept;

   // contents start at zero
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         storage[i] = '0;
      end
   end

   assign accept = (bif.req_op != OP_NONE) && !bif.busy;

   // storage write and read data shift
   always_ff @(posedge clk) begin
      if (accept && (bif.req_op == OP_WRITE)) begin
         storage[bif.req_addr] <= bif.req_data;
      end
      pipe_data[0] <= storage[bif.req_addr];
      for (int i = 1; i < BANK_LATENCY; i++) begin
         pipe_data[i] <= pipe_data[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pipe_vld <= '0;
         busy_cnt <= '0;
      end else begin
         pipe_vld[0] <= accept && (bif.req_op == OP_READ);
         for (int i = 1; i < BANK_LATENCY; i++) begin
            pipe_vld[i] <= pipe_vld[i-1];
         end
         // busy for BANK_LATENCY cycles after each accept
         if (accept) begin
            busy_cnt <= BUSY_W'(BANK_LATENCY);
         end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
         end
      end
   end

   assign bif.busy      = (busy_cnt != '0);
   assign bif.ret_valid = pipe_vld[BANK_LATENCY-1];
   assign bif.ret_data  = pipe_data[BANK_LATENCY-1];

endmodule

// File: design/mem_sys_pkg.sv
//////////////////////////////////////////////////////////////////////
// memory system package
// widths and address fields for the 16-bit cache and banked memory,
// plus the controller state and bank opcode enums
//////////////////////////////////////////////////////////////////////
package mem_sys_pkg;

   // byte address and data word
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;

   // address split is tag / index / word / byte
   // tag sits in bits 15 to 11
   localparam int TAG_W = 5;
   // line index in bits 10 to 3
   localparam int INDEX_W = 8;
   // word in line in bits 2 to 1, doubles as the bank number
   localparam int WORD_W = 2;

   // one bank per word of a line
   localparam int NUM_BANKS = 2 ** WORD_W;
   // word address inside one bank
   localparam int BANK_DEPTH_W = ADDR_W - 1 - WORD_W;

   typedef enum logic [1:0] {
      OP_NONE,
      OP_READ,
      OP_WRITE
   } bank_op_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_COMPARE,
      ST_WB_ISSUE,
      ST_WB_DRAIN,
      ST_FILL_ISSUE,
      ST_FILL_WAIT,
      ST_ACCESS,
      ST_DONE
   } ctrl_state_e;

endpackage

// File: design/mem_system.sv
//////////////////////////////////////////////////////////////////////
// memory system top
// host port into a write-back cache backed by four interleaved banks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_system import mem_sys_pkg::*; #(
   parameter int BANK_LATENCY = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [ADDR_W-1:0] Addr,
   input  logic [DATA_W-1:0] DataIn,
   input  logic              Rd,
   input  logic              Wr,
   output logic [DATA_W-1:0] DataOut,
   output logic              Done,
   output logic              Stall,
   output logic              CacheHit,
   output logic              err
);
   // controller to cache array
   logic               lookup;
   logic               wr_word;
   logic [DATA_W-1:0]  wr_data;
   logic [INDEX_W-1:0] index;
   logic [WORD_W-1:0]  word;
   logic [TAG_W-1:0]   tag;
   logic               fill_en;
   logic               mark_dirty;
   // cache array lookup results
   logic               hit;
   logic               valid;
   logic               dirty;
   logic [TAG_W-1:0]   victim_tag;
   logic [DATA_W-1:0]  rd_data;
   // controller to dispatcher
   bank_op_e           mem_op;
   logic [ADDR_W-2:0]  mem_addr;
   logic [DATA_W-1:0]  mem_wdata;
   logic               mem_accept;
   // fill stream from the collector
   logic               fill_valid;
   logic [WORD_W-1:0]  fill_word;
   logic [DATA_W-1:0]  fill_data;

   bank_if bif [NUM_BANKS] ();

   cache_ctrl #(.BANK_LATENCY(BANK_LATENCY)) u_ctrl (
      .clk(clk), .rst_n(rst_n), .Addr(Addr), .DataIn(DataIn), .Rd(Rd), .Wr(Wr),
      .hit(hit), .valid(valid), .dirty(dirty), .victim_tag(victim_tag),
      .rd_data(rd_data), .mem_accept(mem_accept), .fill_valid(fill_valid),
      .lookup(lookup), .wr_word(wr_word), .wr_data(wr_data), .index(index),
      .word(word), .tag(tag), .fill_en(fill_en), .mark_dirty(mark_dirty),
      .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .DataOut(DataOut), .Done(Done), .Stall(Stall), .CacheHit(CacheHit), .err(err)
   );

   cache_array u_array (
      .clk(clk), .rst_n(rst_n), .lookup(lookup), .index(index), .word(word),
      .tag(tag), .wr_word(wr_word), .wr_data(wr_data), .fill_en(fill_en),
      .fill_valid(fill_valid), .fill_word(fill_word), .fill_data(fill_data),
      .mark_dirty(mark_dirty), .hit(hit), .valid(valid), .dirty(dirty),
      .victim_tag(victim_tag), .rd_data(rd_data)
   );

   bank_dispatch u_disp (
      .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_accept(mem_accept), .bif(bif)
   );

   // one bank per word of a line
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      mem_bank #(.BANK_LATENCY(BANK_LATENCY)) u_bank (
         .clk(clk), .rst_n(rst_n), .bif(bif[b])
      );
   end

   read_collect u_coll (
      .clk(clk), .rst_n(rst_n), .bif(bif),
      .fill_valid(fill_valid), .fill_word(fill_word), .fill_data(fill_data)
   );

endmodule

// File: design/read_collect.sv
//////////////////////////////////////////////////////////////////////
// read return collector
// merges bank read returns into one registered fill stream, the bank
// number giving the word of the line
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module read_collect import mem_sys_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   bank_if.coll              bif [NUM_BANKS],
   output logic              fill_valid,
   output logic [WORD_W-1:0] fill_word,
   output logic [DATA_W-1:0] fill_data
);
   logic [NUM_BANKS-1:0] vld_vec;
   logic [DATA_W-1:0]    data_vec [NUM_BANKS];
   logic [WORD_W-1:0]    sel_word;
   logic [DATA_W-1:0]    sel_data;

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_tap
      assign vld_vec[b]  = bif[b].ret_valid;
      assign data_vec[b] = bif[b].ret_data;
   end

   // banks return on distinct cycles, at most one bit set
   always_comb begin
      sel_word = '0;
      sel_data = data_vec[0];
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (vld_vec[b]) begin
            sel_word = WORD_W'(b);
            sel_data = data_vec[b];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fill_valid <= 1'b0;
      end else begin
         fill_valid <= |vld_vec;
      end
      fill_word <= sel_word;
      fill_data <= sel_data;
   end

endmodule

// File: flist.f
design/mem_sys_pkg.sv
design/bank_if.sv
design/cache_array.sv
design/cache_ctrl.sv
design/bank_dispatch.sv
design/mem_bank.sv
design/read_collect.sv
design/mem_system.sv
testbench/tb_mem_system.sv

// File: testbench/tb_mem_system.sv
//////////////////////////////////////////////////////////////////////
// memory system testbench
// directed and seeded random host traffic, checked against a flat
// word memory model and a tag/valid model of the cache lines
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_mem_system import mem_sys_pkg::*; ();

   localparam int BANK_LATENCY = 4;
   // dirty miss at latency 4, rounded up
   localparam int MISS_CYCLES  = 32;
   localparam int DIRECTED_OPS = 48;
   localparam int RAND_OPS     = 400;
   localparam int CYCLE_LIMIT  = (DIRECTED_OPS + RAND_OPS) * MISS_CYCLES + 200;
   // sampling edge, compare, access
   localparam int HIT_LAT      = 3;
   localparam int MEM_WORDS    = 2 ** (ADDR_W - 1);
   localparam int NUM_LINES    = 2 ** INDEX_W;

   logic              clk;
   logic              rst_n;
   logic [ADDR_W-1:0] Addr;
   logic [DATA_W-1:0] DataIn;
   logic              Rd;
   logic              Wr;
   logic [DATA_W-1:0] DataOut;
   logic              Done;
   logic              Stall;
   logic              CacheHit;
   logic              err;

   // reference models
   logic [DATA_W-1:0] mem_model  [MEM_WORDS];
   logic [TAG_W-1:0]  line_tag   [NUM_LINES];
   logic              line_valid [NUM_LINES];

   int          cycle_cnt = 0;
   int          checks = 0;
   int          errors = 0;

   mem_system #(.BANK_LATENCY(BANK_LATENCY)) i_dut (
      .clk(clk), .rst_n(rst_n), .Addr(Addr), .DataIn(DataIn), .Rd(Rd), .Wr(Wr),
      .DataOut(DataOut), .Done(Done), .Stall(Stall), .CacheHit(CacheHit), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // watchdog
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] t,
                                                   input logic [INDEX_W-1:0] i,
                                                   input logic [WORD_W-1:0] w);
      return {t, i, w, 1'b0};
   endfunction

   // hit if the line holds this tag
   function automatic logic predict_hit(input logic [ADDR_W-1:0] a);
      logic [INDEX_W-1:0] idx;
      idx = a[WORD_W+1 +: INDEX_W];
      return line_valid[idx] && (line_tag[idx] == a[ADDR_W-1 -: TAG_W]);
   endfunction

   // one host read or write, wait for Done, check, update models
   task automatic host_access(input logic is_wr, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d);
      logic              exp_err;
      logic              exp_hit;
      logic [DATA_W-1:0] exp_data;
      int                lat;
      exp_err  = a[0];
      exp_hit  = !exp_err && predict_hit(a);
      exp_data = mem_model[a[ADDR_W-1:1]];
      // called on a falling edge with the FSM in ST_IDLE
      Addr   = a;
      DataIn = d;
      Rd     = !is_wr;
      Wr     = is_wr;
      @(negedge clk);
      lat = 1;
      while (!Done && (lat < 2 * MISS_CYCLES)) begin
         checks++;
         if (!Stall) begin
            $display("Stall low while a request to %h is pending", a);
            errors++;
         end
         @(negedge clk);
         lat++;
      end
      if (!Done) begin
         $display("Done never came for the access to %h", a);
         errors++;
      end else begin
         checks += 4;
         if (Stall) begin
            $display("Stall still high in the Done cycle at %h", a);
            errors++;
         end
         if (err !== exp_err) begin
            $display("Mismatch err at %h: got %h, expected %h", a, err, exp_err);
            errors++;
         end
         if (CacheHit !== exp_hit) begin
            $display("Mismatch CacheHit at %h: got %h, expected %h", a, CacheHit, exp_hit);
            errors++;
         end
         // hits and refused addresses have a fixed response time
         if ((exp_hit || exp_err) && (lat != HIT_LAT)) begin
            $display("Mismatch Done latency at %h: got %h, expected %h", a, lat, HIT_LAT);
            errors++;
         end else if (!exp_hit && !exp_err && (lat <= HIT_LAT)) begin
            $display("Miss at %h finished as fast as a hit", a);
            errors++;
         end
         if (!is_wr && !exp_err) begin
            checks++;
            if (DataOut !== exp_data) begin
               $display("Mismatch DataOut at %h: got %h, expected %h", a, DataOut, exp_data);
               errors++;
            end
         end
      end
      Rd = 1'b0;
      Wr = 1'b0;
      // ST_DONE, response pulses gone
      @(negedge clk);
      checks++;
      if (Done || CacheHit || err) begin
         $display("Response to %h lasted more than one cycle", a);
         errors++;
      end
      if (!exp_err) begin
         if (is_wr) begin
            mem_model[a[ADDR_W-1:1]] = d;
         end
         line_valid[a[WORD_W+1 +: INDEX_W]] = 1'b1;
         line_tag[a[WORD_W+1 +: INDEX_W]]   = a[ADDR_W-1 -: TAG_W];
      end
   endtask

   // outputs stay quiet with no request
   task automatic check_quiet(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         checks++;
         if (Done || Stall || CacheHit || err) begin
            $display("Output active without a request, cycle %0d", i);
            errors++;
         end
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      if (errors == err_start) begin
         $display("test %-18s ok", name);
      end else begin
         $display("test %-18s FAIL (%0d errors)", name, errors - err_start);
      end
   endtask

   initial begin
      int                err_start;
      logic [ADDR_W-1:0] a;
      logic [TAG_W-1:0]  t;
      void'($urandom(40));
      rst_n  = 1'b0;
      Addr   = '0;
      DataIn = '0;
      Rd     = 1'b0;
      Wr     = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_model[i] = '0;
      end
      for (int i = 0; i < NUM_LINES; i++) begin
         line_valid[i] = 1'b0;
         line_tag[i]   = '0;
      end
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      err_start = errors;
      check_quiet(20);
      report_test("idle after reset", err_start);

      // fresh lines miss, then hit
      err_start = errors;
      for (int i = 0; i < 4; i++) begin
         a = make_addr('0, INDEX_W'(16 + i), WORD_W'($urandom));
         host_access(1'b0, a, '0);
         host_access(1'b0, a, '0);
      end
      report_test("read miss and hit", err_start);

      err_start = errors;
      for (int i = 0; i < 4; i++) begin
         a = make_addr('0, INDEX_W'(16 + i), WORD_W'(i));
         host_access(1'b1, a, DATA_W'($urandom));
         host_access(1'b0, a, '0);
      end
      report_test("write hit", err_start);

      // same index, three tags, each eviction dirty
      err_start = errors;
      for (int k = 1; k <= 3; k++) begin
         for (int w = 0; w < 4; w++) begin
            host_access(1'b1, make_addr(TAG_W'(k), 8'd40, WORD_W'(w)), DATA_W'($urandom));
         end
      end
      for (int k = 1; k <= 3; k++) begin
         for (int w = 0; w < 4; w++) begin
            host_access(1'b0, make_addr(TAG_W'(k), 8'd40, WORD_W'(w)), '0);
         end
      end
      report_test("conflict writeback", err_start);

      // odd address refused, aligned word untouched
      err_start = errors;
      for (int i = 0; i < 4; i++) begin
         a = make_addr('0, INDEX_W'(16 + i), WORD_W'(i));
         host_access(i[0], a | 16'h0001, DATA_W'($urandom));
         host_access(1'b0, a, '0);
      end
      report_test("unaligned address", err_start);

      // small window, 4 tags on 4 indexes
      err_start = errors;
      for (int n = 0; n < RAND_OPS; n++) begin
         t = TAG_W'($urandom % 4);
         a = make_addr(t, INDEX_W'(64 + ($urandom % 4)), WORD_W'($urandom));
         host_access(1'($urandom), a, DATA_W'($urandom));
      end
      report_test("random traffic", err_start);

      $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle_cnt);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
